// File: source/taylor_pkg.sv
`default_nettype none

package taylor_pkg;

    // ------------------------------------------------------------
    // datapath widths
    // ------------------------------------------------------------
    localparam int SAMPLE_W = 18;
    localparam int FRAC_W   = 16;
    localparam int ACC_W    = 48;
    localparam int N_TERMS  = 10;
    localparam int IDX_W    = 4;

    // 1.0 in Q2.16
    localparam logic signed [SAMPLE_W-1:0] ONE_Q = 18'sh10000;

    // function select
    localparam int FUNC_W = 2;
    localparam logic [FUNC_W-1:0] FUNC_SIN  = 2'd0;
    localparam logic [FUNC_W-1:0] FUNC_COS  = 2'd1;
    localparam logic [FUNC_W-1:0] FUNC_SINH = 2'd2;
    localparam logic [FUNC_W-1:0] FUNC_COSH = 2'd3;

    // slice opcodes
    localparam int OP_W = 2;
    localparam logic [OP_W-1:0] OP_NOP     = 2'd0;
    localparam logic [OP_W-1:0] OP_MUL     = 2'd1;
    localparam logic [OP_W-1:0] OP_MADD    = 2'd2;
    localparam logic [OP_W-1:0] OP_MUL_ONE = 2'd3;

    // derivative sign, two's complement -1/0/+1
    localparam int DERIV_W = 2;
    localparam logic [DERIV_W-1:0] SGN_ZERO = 2'b00;
    localparam logic [DERIV_W-1:0] SGN_POS  = 2'b01;
    localparam logic [DERIV_W-1:0] SGN_NEG  = 2'b11;

    // start-accept edge to done pulse
    localparam int CALC_LATENCY = 56;

    // ------------------------------------------------------------
    // sequencer program
    // ------------------------------------------------------------
    localparam int PC_W  = 3;
    localparam int REP_W = 5;
    localparam logic [PC_W-1:0] PC_IDLE  = 3'd0;
    localparam logic [PC_W-1:0] PC_CAP   = 3'd1;
    localparam logic [PC_W-1:0] PC_SCALE = 3'd2;
    localparam logic [PC_W-1:0] PC_DRAIN = 3'd3;
    localparam logic [PC_W-1:0] PC_POWER = 3'd4;
    localparam logic [PC_W-1:0] PC_SUM   = 3'd5;
    localparam logic [PC_W-1:0] PC_RES   = 3'd6;
    localparam logic [PC_W-1:0] PC_DONE  = 3'd7;

    // task word bit positions
    localparam int TASK_W     = 15;
    localparam int TK_WAIT_IN = 0;
    localparam int TK_MOV_I_0 = 1;
    localparam int TK_MOV_I_1 = 2;
    localparam int TK_INC_I   = 3;
    localparam int TK_REP_2   = 4;
    localparam int TK_REP_10  = 5;
    localparam int TK_REP_20  = 6;
    localparam int TK_REP_22  = 7;
    localparam int TK_MUL_XR  = 8;
    localparam int TK_MUL_QT  = 9;
    localparam int TK_SEED    = 10;
    localparam int TK_MADD    = 11;
    localparam int TK_WR_TERM = 12;
    localparam int TK_MOV_RES = 13;
    localparam int TK_JP_0    = 14;

endpackage

`default_nettype wire

// File: source/taylor_coef_rom.sv
`default_nettype none

module taylor_coef_rom
    import taylor_pkg::*;
(
    input  wire         [FUNC_W-1:0]   i_func,
    input  wire         [IDX_W-1:0]    i_idx,
    output logic signed [SAMPLE_W-1:0] o_recip,
    output logic        [DERIV_W-1:0]  o_deriv
);

    // 1/i in Q2.16, truncated
    always_comb begin
        case (i_idx)
            4'd1:    o_recip = 18'h10000;
            4'd2:    o_recip = 18'h08000;
            4'd3:    o_recip = 18'h05555;
            4'd4:    o_recip = 18'h04000;
            4'd5:    o_recip = 18'h03333;
            4'd6:    o_recip = 18'h02aaa;
            4'd7:    o_recip = 18'h02492;
            4'd8:    o_recip = 18'h02000;
            4'd9:    o_recip = 18'h01c71;
            4'd10:   o_recip = 18'h01999;
            default: o_recip = '0;
        endcase
    end

    // derivatives at zero repeat every four (sin/cos) or two (sinh/cosh)
    always_comb begin
        o_deriv = SGN_ZERO;
        case (i_func)
            FUNC_SIN: begin
                case (i_idx[1:0])
                    2'd1:    o_deriv = SGN_POS;
                    2'd3:    o_deriv = SGN_NEG;
                    default: o_deriv = SGN_ZERO;
                endcase
            end
            FUNC_COS: begin
                case (i_idx[1:0])
                    2'd0:    o_deriv = SGN_POS;
                    2'd2:    o_deriv = SGN_NEG;
                    default: o_deriv = SGN_ZERO;
                endcase
            end
            FUNC_SINH: o_deriv = i_idx[0] ? SGN_POS : SGN_ZERO;
            FUNC_COSH: o_deriv = i_idx[0] ? SGN_ZERO : SGN_POS;
            default:   o_deriv = SGN_ZERO;
        endcase
    end

endmodule

`default_nettype wire

// File: source/taylor_mac_lane.sv
`default_nettype none

module taylor_mac_lane
    import taylor_pkg::*;
(
    input  wire                        reset,
    input  wire                        clk,
    input  wire         [OP_W-1:0]     i_op,
    input  wire  signed [SAMPLE_W-1:0] i_a,
    input  wire  signed [SAMPLE_W-1:0] i_b,
    output logic signed [ACC_W-1:0]    o_p,
    output logic signed [SAMPLE_W-1:0] o_p_hi
);

    logic        [OP_W-1:0]       op_r;
    logic signed [SAMPLE_W-1:0]   a_r;
    logic signed [SAMPLE_W-1:0]   b_r;
    logic signed [SAMPLE_W-1:0]   mult_b;
    logic signed [2*SAMPLE_W-1:0] prod;
    logic signed [ACC_W-1:0]      prod_ext;

    // ------------------------------------------------------------
    // stage one: op and operand registers
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk)
            op_r <= OP_NOP;
        else
            op_r <= i_op;
    end

    always_ff @(posedge reset) begin
        a_r <= i_a;
        b_r <= i_b;
    end

    assign mult_b   = (op_r == OP_MUL_ONE) ? ONE_Q : b_r;
    assign prod     = a_r * mult_b;
    assign prod_ext = {{(ACC_W - 2*SAMPLE_W){prod[2*SAMPLE_W-1]}}, prod};

    // ------------------------------------------------------------
    // stage two: product / accumulator
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            o_p <= '0;
        end else begin
            case (op_r)
                OP_MUL, OP_MUL_ONE: o_p <= prod_ext;
                OP_MADD:            o_p <= o_p + prod_ext;
                default:            o_p <= o_p;
            endcase
        end
    end

    // Q2.16 field of the Q4.32 product
    assign o_p_hi = o_p[FRAC_W +: SAMPLE_W];

    a_op_known: assert property (@(posedge reset) disable iff (clk) !$isunknown(i_op));

endmodule

`default_nettype wire

// File: source/taylor_term_file.sv
`default_nettype none

module taylor_term_file
    import taylor_pkg::*;
(
    input  wire                        reset,
    input  wire                        clk,
    input  wire                        i_wr_en,
    input  wire         [IDX_W-1:0]    i_wr_idx,
    input  wire         [IDX_W-1:0]    i_rd_idx,
    input  wire  signed [SAMPLE_W-1:0] i_dl,
    input  wire  signed [SAMPLE_W-1:0] i_dr,
    output logic signed [SAMPLE_W-1:0] o_tl,
    output logic signed [SAMPLE_W-1:0] o_tr
);

    logic        [1:0]          wr_en_d;
    logic        [IDX_W-1:0]    wr_idx_d1;
    logic        [IDX_W-1:0]    wr_idx_d2;
    logic signed [SAMPLE_W-1:0] tl_mem [1:N_TERMS];
    logic signed [SAMPLE_W-1:0] tr_mem [1:N_TERMS];
    logic                       rd_ok;

    // delay line, two stages to match the slice
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_en_d   <= '0;
            wr_idx_d1 <= '0;
            wr_idx_d2 <= '0;
        end else begin
            wr_en_d   <= {wr_en_d[0], i_wr_en};
            wr_idx_d1 <= i_wr_idx;
            wr_idx_d2 <= wr_idx_d1;
        end
    end

    always_ff @(posedge reset) begin
        if (wr_en_d[1]) begin
            tl_mem[wr_idx_d2] <= i_dl;
            tr_mem[wr_idx_d2] <= i_dr;
        end
    end

    // index 0 reads as zero
    assign rd_ok = (i_rd_idx != '0) && (i_rd_idx <= N_TERMS);
    assign o_tl  = rd_ok ? tl_mem[i_rd_idx] : '0;
    assign o_tr  = rd_ok ? tr_mem[i_rd_idx] : '0;

    a_wr_idx_range: assert property (@(posedge reset) disable iff (clk)
        wr_en_d[1] |-> (wr_idx_d2 != '0) && (wr_idx_d2 <= N_TERMS));

endmodule

`default_nettype wire

// File: source/taylor_sequencer.sv
`default_nettype none

module taylor_sequencer
    import taylor_pkg::*;
(
    input  wire                        reset,
    input  wire                        clk,
    input  wire                        i_start,
    input  wire        [FUNC_W-1:0]    i_func_sel,
    input  wire signed [SAMPLE_W-1:0]  i_xl,
    input  wire signed [SAMPLE_W-1:0]  i_xr,
    input  wire signed [SAMPLE_W-1:0]  i_recip,
    input  wire        [DERIV_W-1:0]   i_deriv,
    input  wire signed [SAMPLE_W-1:0]  i_pl_hi,
    input  wire signed [SAMPLE_W-1:0]  i_pr_hi,
    input  wire signed [SAMPLE_W-1:0]  i_tl,
    input  wire signed [SAMPLE_W-1:0]  i_tr,
    output logic                       o_busy,
    output logic                       o_done,
    output logic signed [SAMPLE_W-1:0] o_resl,
    output logic signed [SAMPLE_W-1:0] o_resr,
    output logic        [FUNC_W-1:0]   o_func,
    output logic        [IDX_W-1:0]    o_idx,
    output logic        [OP_W-1:0]     o_op,
    output logic signed [SAMPLE_W-1:0] o_al,
    output logic signed [SAMPLE_W-1:0] o_bl,
    output logic signed [SAMPLE_W-1:0] o_ar,
    output logic signed [SAMPLE_W-1:0] o_br,
    output logic                       o_wr_en,
    output logic        [IDX_W-1:0]    o_wr_idx,
    output logic        [IDX_W-1:0]    o_rd_idx
);

    logic        [PC_W-1:0]     pc;
    logic        [TASK_W-1:0]   tasks;
    logic        [REP_W-1:0]    rep_cnt;
    logic        [REP_W-1:0]    rep_max;
    logic                       rep_busy;
    logic                       accept;
    logic        [IDX_W-1:0]    idx;
    logic        [FUNC_W-1:0]   func_r;
    logic signed [SAMPLE_W-1:0] xl_r;
    logic signed [SAMPLE_W-1:0] xr_r;
    logic signed [SAMPLE_W-1:0] sign_q;
    logic                       last_idx;

    assign last_idx = (idx == N_TERMS);

    // ------------------------------------------------------------
    // task decode
    // ------------------------------------------------------------
    always_comb begin
        tasks = '0;
        case (pc)
            PC_IDLE: tasks[TK_WAIT_IN] = 1'b1;
            PC_CAP:  tasks[TK_MOV_I_1] = 1'b1;
            PC_SCALE: begin
                // q_i = x * (1/i), back to back
                tasks[TK_REP_10]  = 1'b1;
                tasks[TK_MUL_XR]  = 1'b1;
                tasks[TK_WR_TERM] = 1'b1;
                tasks[TK_MOV_I_1] = last_idx;
                tasks[TK_INC_I]   = !last_idx;
            end
            PC_DRAIN: tasks[TK_REP_2] = 1'b1;
            PC_POWER: begin
                // t_i = t_(i-1) * q_i, issue on even counts
                tasks[TK_REP_20]  = 1'b1;
                tasks[TK_MUL_QT]  = !rep_cnt[0];
                tasks[TK_WR_TERM] = !rep_cnt[0];
                tasks[TK_MOV_I_0] = rep_cnt[0] && last_idx;
                tasks[TK_INC_I]   = rep_cnt[0] && !last_idx;
            end
            PC_SUM: begin
                tasks[TK_REP_22] = 1'b1;
                tasks[TK_SEED]   = !rep_cnt[0] && (idx == '0);
                tasks[TK_MADD]   = !rep_cnt[0] && (idx != '0);
                tasks[TK_INC_I]  = rep_cnt[0] && !last_idx;
            end
            PC_RES:  tasks[TK_MOV_RES] = 1'b1;
            PC_DONE: tasks[TK_JP_0] = 1'b1;
            default: tasks[TK_JP_0] = 1'b1;
        endcase
    end

    assign accept = tasks[TK_WAIT_IN] && i_start;

    // repeat count per loop
    always_comb begin
        rep_max = '0;
        if (tasks[TK_REP_2])
            rep_max = REP_W'(1);
        else if (tasks[TK_REP_10])
            rep_max = REP_W'(N_TERMS - 1);
        else if (tasks[TK_REP_20])
            rep_max = REP_W'(2 * N_TERMS - 1);
        else if (tasks[TK_REP_22])
            rep_max = REP_W'(2 * N_TERMS + 1);
    end

    assign rep_busy = (rep_cnt != rep_max);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pc      <= PC_IDLE;
            rep_cnt <= '0;
            idx     <= '0;
            func_r  <= FUNC_SIN;
        end else begin
            rep_cnt <= rep_busy ? rep_cnt + 1'b1 : '0;
            if (tasks[TK_JP_0])
                pc <= PC_IDLE;
            else if ((tasks[TK_WAIT_IN] && !i_start) || rep_busy)
                pc <= pc;
            else
                pc <= pc + 1'b1;
            if (tasks[TK_MOV_I_0])
                idx <= '0;
            else if (tasks[TK_MOV_I_1])
                idx <= IDX_W'(1);
            else if (tasks[TK_INC_I])
                idx <= idx + 1'b1;
            if (accept)
                func_r <= i_func_sel;
        end
    end

    // sample capture
    always_ff @(posedge reset) begin
        if (accept) begin
            xl_r <= i_xl;
            xr_r <= i_xr;
        end
    end

    // ------------------------------------------------------------
    // operand selection
    // ------------------------------------------------------------
    always_comb begin
        case (i_deriv)
            SGN_POS: sign_q = ONE_Q;
            SGN_NEG: sign_q = -ONE_Q;
            default: sign_q = '0;
        endcase
    end

    always_comb begin
        o_op = OP_NOP;
        o_al = '0;
        o_bl = '0;
        o_ar = '0;
        o_br = '0;
        if (tasks[TK_MUL_XR]) begin
            o_op = OP_MUL;
            o_al = xl_r;
            o_bl = i_recip;
            o_ar = xr_r;
            o_br = i_recip;
        end else if (tasks[TK_MUL_QT]) begin
            // previous term comes straight back from the slices
            o_op = OP_MUL;
            o_al = i_tl;
            o_bl = (idx == IDX_W'(1)) ? ONE_Q : i_pl_hi;
            o_ar = i_tr;
            o_br = (idx == IDX_W'(1)) ? ONE_Q : i_pr_hi;
        end else if (tasks[TK_SEED]) begin
            o_op = OP_MUL_ONE;
            o_al = sign_q;
            o_ar = sign_q;
        end else if (tasks[TK_MADD]) begin
            o_op = OP_MADD;
            o_al = sign_q;
            o_bl = i_tl;
            o_ar = sign_q;
            o_br = i_tr;
        end
    end

    assign o_busy   = (pc != PC_IDLE);
    assign o_func   = func_r;
    assign o_idx    = idx;
    assign o_wr_en  = tasks[TK_WR_TERM];
    assign o_wr_idx = idx;
    assign o_rd_idx = idx;

    // results only live in the done cycle
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            o_done <= 1'b0;
            o_resl <= '0;
            o_resr <= '0;
        end else if (tasks[TK_MOV_RES]) begin
            o_done <= 1'b1;
            o_resl <= i_pl_hi;
            o_resr <= i_pr_hi;
        end else begin
            o_done <= 1'b0;
            o_resl <= '0;
            o_resr <= '0;
        end
    end

    a_done_pulse: assert property (@(posedge reset) disable iff (clk) o_done |=> !o_done);
    a_idx_range: assert property (@(posedge reset) disable iff (clk) o_idx <= N_TERMS);
    a_latency: assert property (@(posedge reset) disable iff (clk)
        accept |-> ##(CALC_LATENCY + 1) o_done);

endmodule

`default_nettype wire

// File: source/taylor_calc_top.sv
`default_nettype none

module taylor_calc_top
    import taylor_pkg::*;
(
    input  wire                        reset,
    input  wire                        clk,
    input  wire                        i_start,
    input  wire        [FUNC_W-1:0]    i_func_sel,
    input  wire signed [SAMPLE_W-1:0]  i_xl,
    input  wire signed [SAMPLE_W-1:0]  i_xr,
    output wire                        o_busy,
    output wire                        o_done,
    output wire signed [SAMPLE_W-1:0]  o_resl,
    output wire signed [SAMPLE_W-1:0]  o_resr
);

    wire        [FUNC_W-1:0]   func;
    wire        [IDX_W-1:0]    idx;
    wire signed [SAMPLE_W-1:0] recip;
    wire        [DERIV_W-1:0]  deriv;
    wire        [OP_W-1:0]     op;
    wire signed [SAMPLE_W-1:0] al;
    wire signed [SAMPLE_W-1:0] bl;
    wire signed [SAMPLE_W-1:0] ar;
    wire signed [SAMPLE_W-1:0] br;
    wire signed [SAMPLE_W-1:0] pl_hi;
    wire signed [SAMPLE_W-1:0] pr_hi;
    wire signed [SAMPLE_W-1:0] tl;
    wire signed [SAMPLE_W-1:0] tr;
    wire                       wr_en;
    wire        [IDX_W-1:0]    wr_idx;
    wire        [IDX_W-1:0]    rd_idx;

    taylor_sequencer u_seq (
        .reset      (reset),
        .clk        (clk),
        .i_start    (i_start),
        .i_func_sel (i_func_sel),
        .i_xl       (i_xl),
        .i_xr       (i_xr),
        .i_recip    (recip),
        .i_deriv    (deriv),
        .i_pl_hi    (pl_hi),
        .i_pr_hi    (pr_hi),
        .i_tl       (tl),
        .i_tr       (tr),
        .o_busy     (o_busy),
        .o_done     (o_done),
        .o_resl     (o_resl),
        .o_resr     (o_resr),
        .o_func     (func),
        .o_idx      (idx),
        .o_op       (op),
        .o_al       (al),
        .o_bl       (bl),
        .o_ar       (ar),
        .o_br       (br),
        .o_wr_en    (wr_en),
        .o_wr_idx   (wr_idx),
        .o_rd_idx   (rd_idx)
    );

    taylor_coef_rom u_rom (
        .i_func  (func),
        .i_idx   (idx),
        .o_recip (recip),
        .o_deriv (deriv)
    );

    taylor_term_file u_terms (
        .reset    (reset),
        .clk      (clk),
        .i_wr_en  (wr_en),
        .i_wr_idx (wr_idx),
        .i_rd_idx (rd_idx),
        .i_dl     (pl_hi),
        .i_dr     (pr_hi),
        .o_tl     (tl),
        .o_tr     (tr)
    );

    // left and right lanes share the opcode
    taylor_mac_lane u_lane_l (
        .reset  (reset),
        .clk    (clk),
        .i_op   (op),
        .i_a    (al),
        .i_b    (bl),
        .o_p    (),
        .o_p_hi (pl_hi)
    );

    taylor_mac_lane u_lane_r (
        .reset  (reset),
        .clk    (clk),
        .i_op   (op),
        .i_a    (ar),
        .i_b    (br),
        .o_p    (),
        .o_p_hi (pr_hi)
    );

endmodule

`default_nettype wire

// File: dv/taylor_calc_tb.sv
`default_nettype none

module taylor_calc_tb
    import taylor_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED         = 32'hdf2e;
    localparam int          N_RANDOM     = 6;
    localparam int          RESET_CYCLES = 16;
    localparam int          DONE_TIMEOUT = CALC_LATENCY + 16;

    localparam logic signed [SAMPLE_W-1:0] X_MAX = 18'sh0ffff;
    localparam logic signed [SAMPLE_W-1:0] X_MIN = -ONE_Q;

    // reset is the clock and clk is the reset on this block
    logic                       reset;
    logic                       clk;
    logic                       i_start;
    logic        [FUNC_W-1:0]   i_func_sel;
    logic signed [SAMPLE_W-1:0] i_xl;
    logic signed [SAMPLE_W-1:0] i_xr;
    wire                        o_busy;
    wire                        o_done;
    wire signed  [SAMPLE_W-1:0] o_resl;
    wire signed  [SAMPLE_W-1:0] o_resr;

    int   cycle_cnt = 0;
    logic done_prev = 1'b0;

    // outstanding requests in issue order
    logic signed [SAMPLE_W-1:0] exp_l_q [$];
    logic signed [SAMPLE_W-1:0] exp_r_q [$];
    int                         start_q [$];

    taylor_calc_top UUT (
        .reset      (reset),
        .clk        (clk),
        .i_start    (i_start),
        .i_func_sel (i_func_sel),
        .i_xl       (i_xl),
        .i_xr       (i_xr),
        .o_busy     (o_busy),
        .o_done     (o_done),
        .o_resl     (o_resl),
        .o_resr     (o_resr)
    );

    always #5 reset = ~reset;

    always @(posedge reset) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------------------------------------
    // error handling and compare tasks
    // ------------------------------------------------------------
    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_problem(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic compare_sample(input string name, input logic signed [SAMPLE_W-1:0] got,
                                  input logic signed [SAMPLE_W-1:0] exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic verify_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Error: time %0t, %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic expect_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s is %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // at x = 0 only the zeroth term is left
    task automatic check_value_at_zero(input string name, input logic [FUNC_W-1:0] func,
                                       input logic signed [SAMPLE_W-1:0] got);
        logic signed [SAMPLE_W-1:0] exp;
        exp = (func == FUNC_COS || func == FUNC_COSH) ? ONE_Q : '0;
        compare_sample(name, got, exp);
    endtask

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic int derivative_at_zero(input logic [FUNC_W-1:0] func, input int i);
        int d;
        d = 0;
        case (func)
            FUNC_SIN:  d = (i % 4 == 1) ? 1 : ((i % 4 == 3) ? -1 : 0);
            FUNC_COS:  d = (i % 4 == 0) ? 1 : ((i % 4 == 2) ? -1 : 0);
            FUNC_SINH: d = (i % 2 == 1) ? 1 : 0;
            default:   d = (i % 2 == 0) ? 1 : 0;
        endcase
        return d;
    endfunction

    function automatic logic signed [SAMPLE_W-1:0] taylor_model(
        input logic [FUNC_W-1:0] func,
        input logic signed [SAMPLE_W-1:0] x
    );
        logic signed [SAMPLE_W-1:0] q [1:N_TERMS];
        logic signed [SAMPLE_W-1:0] t [0:N_TERMS];
        logic signed [ACC_W-1:0]    prod;
        logic signed [ACC_W-1:0]    acc;
        int                         sgn;

        // phase A scales x by the truncated 1/i
        for (int i = 1; i <= N_TERMS; i++) begin
            prod = ACC_W'(x) * ACC_W'((1 << FRAC_W) / i);
            q[i] = prod[FRAC_W +: SAMPLE_W];
        end

        // phase B builds t_i = t_(i-1) * q_i
        t[0] = ONE_Q;
        for (int i = 1; i <= N_TERMS; i++) begin
            prod = ACC_W'(q[i]) * ACC_W'(t[i-1]);
            t[i] = prod[FRAC_W +: SAMPLE_W];
        end

        // phase C keeps the full 48-bit sum
        sgn = derivative_at_zero(func, 0);
        acc = ACC_W'(sgn * (1 << FRAC_W)) * ACC_W'(ONE_Q);
        for (int i = 1; i <= N_TERMS; i++) begin
            sgn = derivative_at_zero(func, i);
            acc = acc + ACC_W'(sgn * (1 << FRAC_W)) * ACC_W'(t[i]);
        end
        return acc[FRAC_W +: SAMPLE_W];
    endfunction

    // |x| < 1.0
    function automatic logic signed [SAMPLE_W-1:0] random_sample();
        int v;
        v = int'($urandom % 32'd131071) - 65535;
        return v[SAMPLE_W-1:0];
    endfunction

    // ------------------------------------------------------------
    // stimulus helpers for the falling edge
    // ------------------------------------------------------------
    task automatic issue_request(input logic [FUNC_W-1:0] func,
                                 input logic signed [SAMPLE_W-1:0] xl,
                                 input logic signed [SAMPLE_W-1:0] xr,
                                 input bit accepted);
        i_start    = 1'b1;
        i_func_sel = func;
        i_xl       = xl;
        i_xr       = xr;
        if (accepted) begin
            exp_l_q.push_back(taylor_model(func, xl));
            exp_r_q.push_back(taylor_model(func, xr));
            start_q.push_back(cycle_cnt + 1);
        end
        @(negedge reset);
        i_start = 1'b0;
        // garbage on the inputs once the request is taken
        i_func_sel = FUNC_W'($urandom);
        i_xl       = random_sample();
        i_xr       = random_sample();
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do begin
            @(negedge reset);
            n++;
            if (n > DONE_TIMEOUT)
                report_problem("timeout while waiting for the done pulse");
        end while (!o_done);
    endtask

    // ------------------------------------------------------------
    // compare process
    // ------------------------------------------------------------
    always @(negedge reset) begin
        if (!clk) begin
            if (o_done) begin
                if (done_prev)
                    report_problem("done pulse lasted longer than one cycle");
                if (exp_l_q.size() == 0)
                    report_problem("done pulse without an accepted request");
                compare_sample("o_resl", o_resl, exp_l_q.pop_front());
                compare_sample("o_resr", o_resr, exp_r_q.pop_front());
                verify_count("latency", cycle_cnt - start_q.pop_front(), CALC_LATENCY);
            end else begin
                compare_sample("o_resl", o_resl, '0);
                compare_sample("o_resr", o_resr, '0);
            end
            done_prev = o_done;
        end
    end

    initial begin
        reset      = 1'b0;
        clk        = 1'b1;
        i_start    = 1'b0;
        i_func_sel = FUNC_SIN;
        i_xl       = '0;
        i_xr       = '0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge reset);
        @(negedge reset);
        clk = 1'b0;
        @(negedge reset);
        expect_level("o_busy", o_busy, 1'b0);
        expect_level("o_done", o_done, 1'b0);

        // edge inputs back to back
        for (int f = 0; f < 4; f++) begin
            @(negedge reset);
            issue_request(FUNC_W'(f), '0, X_MAX, 1'b1);
            wait_done();
            check_value_at_zero("o_resl", FUNC_W'(f), o_resl);
            @(negedge reset);
            issue_request(FUNC_W'(f), X_MIN, '0, 1'b1);
            wait_done();
            check_value_at_zero("o_resr", FUNC_W'(f), o_resr);
            @(negedge reset);
            issue_request(FUNC_W'(f), X_MAX, X_MIN, 1'b1);
            wait_done();
        end

        // random samples for every function
        for (int f = 0; f < 4; f++) begin
            for (int k = 0; k < N_RANDOM; k++) begin
                @(negedge reset);
                issue_request(FUNC_W'(f), random_sample(), random_sample(), 1'b1);
                wait_done();
            end
        end

        // a start while busy is dropped
        @(negedge reset);
        issue_request(FUNC_SINH, random_sample(), random_sample(), 1'b1);
        repeat (10) @(negedge reset);
        expect_level("o_busy", o_busy, 1'b1);
        issue_request(FUNC_COS, random_sample(), random_sample(), 1'b0);
        wait_done();
        repeat (CALC_LATENCY + 8) @(negedge reset);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/taylor_pkg.sv
source/taylor_coef_rom.sv
source/taylor_mac_lane.sv
source/taylor_term_file.sv
source/taylor_sequencer.sv
source/taylor_calc_top.sv
dv/taylor_calc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the Taylor series testbench with Verilator

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module taylor_calc_tb -f vlog.f -Mdir "$OBJ" -o taylor_calc_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$OBJ/taylor_calc_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qF '*** FAILED ***' "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation ended abnormally with status $run_status"
    exit 1
fi
echo "simulation passed"
exit 0
